/* common/mac_if.sv */
`timescale 1ns/10ps

interface mac_if;

    logic                              term_valid;
    logic signed [rnn_pkg::DATA_W-1:0] weight;
    logic signed [rnn_pkg::DATA_W-1:0] operand;    // fixed-point one for a bias
    logic                              term_first; // clears the sum
    logic                              term_last;  // closes the sum
    logic                              result_valid;
    logic signed [rnn_pkg::DATA_W-1:0] result;

    modport initiator (
        output term_valid,
        output weight,
        output operand,
        output term_first,
        output term_last,
        input  result_valid,
        input  result
    );

    modport target (
        input  term_valid,
        input  weight,
        input  operand,
        input  term_first,
        input  term_last,
        output result_valid,
        output result
    );

endinterface

/* common/rnn_pkg.sv */
package rnn_pkg;

    // network dimensions
    localparam int VOCAB_SIZE = 76;
    localparam int EMB_SIZE   = 4;
    localparam int HID_SIZE   = 8;

    // signed Q8.8 data path
    localparam int DATA_W    = 16;
    localparam int FRAC_BITS = 8;
    localparam int ACC_W     = 32;

    // fixed-point one, used as the operand of a bias term
    localparam logic signed [DATA_W-1:0] FIX_ONE =
        {{(DATA_W-FRAC_BITS-1){1'b0}}, 1'b1, {FRAC_BITS{1'b0}}};

    // weight memory
    localparam int ADDR_W    = 9;
    localparam int MEM_DEPTH = 416;

    // address map, all offsets in words
    localparam int EMB_BASE  = 0;   // embedding table, token by token
    localparam int W_IH_BASE = 304; // input to hidden, 4 per neuron
    localparam int W_HH_BASE = 336; // hidden to hidden, 8 per neuron
    localparam int B_IH_BASE = 400; // input bias per neuron
    localparam int B_HH_BASE = 408; // hidden bias per neuron

    // sequencer states, fetch order follows the term order of one neuron
    typedef enum logic [2:0] {
        S_IDLE,   // waiting for execute
        S_EMB,    // embedding fetch
        S_HH_W,   // hidden to hidden weights
        S_HH_B,   // hidden bias
        S_IH_W,   // input to hidden weights
        S_IH_B,   // input bias, last term
        S_WAIT,   // accumulator draining
        S_COMMIT  // new hidden becomes old
    } seq_state_t;

endpackage

/* common/weight_rd_if.sv */
`timescale 1ns/10ps

interface weight_rd_if;

    logic                                     en;
    logic        [rnn_pkg::ADDR_W-1:0]        addr;
    logic                                     data_valid; // one cycle after en
    logic signed [rnn_pkg::DATA_W-1:0]        data;

    modport initiator (
        output en,
        output addr,
        input  data_valid,
        input  data
    );

    modport target (
        input  en,
        input  addr,
        output data_valid,
        output data
    );

endinterface

/* list.f */
common/rnn_pkg.sv
common/weight_rd_if.sv
common/mac_if.sv
logic/weight_store.sv
rnn_core/state_bank.sv
rnn_core/neuron_mac.sv
rnn_core/step_sequencer.sv
rnn_core/rnn_cell_top.sv
tb/rnn_cell_chk.sv
tb/rnn_cell_tb.sv

/* logic/weight_store.sv */
`timescale 1ns/10ps

module weight_store (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [rnn_pkg::ADDR_W-1:0] wr_addr,
    input  logic [rnn_pkg::DATA_W-1:0] wr_data,
    weight_rd_if.target                rd
);

    logic [rnn_pkg::DATA_W-1:0] mem [rnn_pkg::MEM_DEPTH];

    // load port, addresses past the table are dropped
    always_ff @(posedge clk)
    begin
        if (wr_en && (wr_addr < rnn_pkg::MEM_DEPTH))
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one request per cycle
    always_ff @(posedge clk)
    begin
        rd.data_valid <= rd.en;
        if (rd.en)
        begin
            rd.data <= mem[rd.addr];
        end
    end

endmodule

/* rnn_core/neuron_mac.sv */
`timescale 1ns/10ps

module neuron_mac (
    input logic   clk,
    input logic   reset,
    mac_if.target mac
);

    localparam int DW = rnn_pkg::DATA_W;
    localparam int AW = rnn_pkg::ACC_W;
    localparam logic signed [AW-1:0] SAT_MAX = AW'((1 << (DW - 1)) - 1);

    logic                 valid_q;
    logic                 first_q;
    logic                 last_q;
    logic signed [AW-1:0] prod_q;
    logic signed [AW-1:0] acc;
    logic signed [AW-1:0] sum;
    logic signed [AW-1:0] scaled;
    logic signed [DW-1:0] activated;

    // stage one, flags follow the product
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q          <= 1'b0;
            first_q          <= 1'b0;
            last_q           <= 1'b0;
            mac.result_valid <= 1'b0;
        end
        else
        begin
            valid_q          <= mac.term_valid;
            first_q          <= mac.term_valid && mac.term_first;
            last_q           <= mac.term_valid && mac.term_last;
            mac.result_valid <= valid_q && last_q;
        end
    end

    always_ff @(posedge clk)
    begin
        prod_q <= mac.weight * mac.operand; // full signed product
    end

    // first term loads instead of adding
    assign sum    = first_q ? prod_q : acc + prod_q;
    assign scaled = sum >>> rnn_pkg::FRAC_BITS;

    // saturate then relu, negatives collapse to zero
    always_comb
    begin
        if (scaled < 0)
            activated = '0;
        else if (scaled > SAT_MAX)
            activated = DW'(SAT_MAX);
        else
            activated = DW'(scaled);
    end

    // stage two
    always_ff @(posedge clk)
    begin
        if (valid_q)
        begin
            acc <= sum;
        end
        if (valid_q && last_q)
        begin
            mac.result <= activated;
        end
    end

endmodule

/* rnn_core/rnn_cell_top.sv */
`timescale 1ns/10ps

module rnn_cell_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        wt_wr_en,
    input  logic        [rnn_pkg::ADDR_W-1:0]           wt_wr_addr,
    input  logic        [rnn_pkg::DATA_W-1:0]           wt_wr_data,
    input  logic        [6:0]                           token,
    input  logic                                        execute,
    output logic                                        busy,
    output logic                                        hidden_valid,
    output logic        [$clog2(rnn_pkg::HID_SIZE)-1:0] hidden_index,
    output logic signed [rnn_pkg::DATA_W-1:0]           hidden_value,
    output logic                                        step_done
);

    localparam int HID_SIZE = rnn_pkg::HID_SIZE;
    localparam int EMB_SIZE = rnn_pkg::EMB_SIZE;

    weight_rd_if wt_rd ();
    mac_if       mac ();

    logic                              emb_wr_en;
    logic        [$clog2(EMB_SIZE)-1:0] emb_wr_idx;
    logic        [$clog2(EMB_SIZE)-1:0] emb_rd_idx;
    logic signed [rnn_pkg::DATA_W-1:0] emb_rd_data;
    logic                              hid_wr_en;
    logic        [$clog2(HID_SIZE)-1:0] hid_wr_idx;
    logic        [$clog2(HID_SIZE)-1:0] hid_rd_idx;
    logic signed [rnn_pkg::DATA_W-1:0] hid_rd_data;
    logic                              commit;

    weight_store i_weight_store (
        .clk     (clk),
        .wr_en   (wt_wr_en),
        .wr_addr (wt_wr_addr),
        .wr_data (wt_wr_data),
        .rd      (wt_rd.target)
    );

    state_bank #(.HID_SIZE(HID_SIZE), .EMB_SIZE(EMB_SIZE)) i_state_bank (
        .clk         (clk),
        .reset       (reset),
        .emb_wr_en   (emb_wr_en),
        .emb_wr_idx  (emb_wr_idx),
        .emb_wr_data (wt_rd.data),  // embedding words come straight from memory
        .hid_wr_en   (hid_wr_en),
        .hid_wr_idx  (hid_wr_idx),
        .hid_wr_data (mac.result),
        .commit      (commit),
        .emb_rd_idx  (emb_rd_idx),
        .emb_rd_data (emb_rd_data),
        .hid_rd_idx  (hid_rd_idx),
        .hid_rd_data (hid_rd_data)
    );

    neuron_mac i_neuron_mac (
        .clk   (clk),
        .reset (reset),
        .mac   (mac.target)
    );

    step_sequencer #(.HID_SIZE(HID_SIZE), .EMB_SIZE(EMB_SIZE)) i_step_sequencer (
        .clk         (clk),
        .reset       (reset),
        .execute     (execute),
        .token       (token),
        .rd          (wt_rd.initiator),
        .mac         (mac.initiator),
        .emb_wr_en   (emb_wr_en),
        .emb_wr_idx  (emb_wr_idx),
        .emb_rd_idx  (emb_rd_idx),
        .hid_rd_idx  (hid_rd_idx),
        .emb_rd_data (emb_rd_data),
        .hid_rd_data (hid_rd_data),
        .hid_wr_en   (hid_wr_en),
        .hid_wr_idx  (hid_wr_idx),
        .commit      (commit),
        .busy        (busy),
        .step_done   (step_done)
    );

    // each neuron is streamed out as it is written
    assign hidden_valid = hid_wr_en;
    assign hidden_index = hid_wr_idx;
    assign hidden_value = mac.result;

endmodule

/* rnn_core/state_bank.sv */
`timescale 1ns/10ps

module state_bank #(
    parameter int HID_SIZE = 8,
    parameter int EMB_SIZE = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              emb_wr_en,
    input  logic        [$clog2(EMB_SIZE)-1:0] emb_wr_idx,
    input  logic signed [rnn_pkg::DATA_W-1:0] emb_wr_data,
    input  logic                              hid_wr_en,
    input  logic        [$clog2(HID_SIZE)-1:0] hid_wr_idx,
    input  logic signed [rnn_pkg::DATA_W-1:0] hid_wr_data,
    input  logic                              commit,
    input  logic        [$clog2(EMB_SIZE)-1:0] emb_rd_idx,
    output logic signed [rnn_pkg::DATA_W-1:0] emb_rd_data,
    input  logic        [$clog2(HID_SIZE)-1:0] hid_rd_idx,
    output logic signed [rnn_pkg::DATA_W-1:0] hid_rd_data
);

    logic signed [rnn_pkg::DATA_W-1:0] emb   [EMB_SIZE];
    logic signed [rnn_pkg::DATA_W-1:0] old_h [HID_SIZE]; // operands of this step
    logic signed [rnn_pkg::DATA_W-1:0] new_h [HID_SIZE]; // results of this step

    always_ff @(posedge clk)
    begin
        if (emb_wr_en)
        begin
            emb[emb_wr_idx] <= emb_wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < HID_SIZE; i++)
            begin
                old_h[i] <= '0;
                new_h[i] <= '0;
            end
        end
        else
        begin
            if (hid_wr_en)
            begin
                new_h[hid_wr_idx] <= hid_wr_data;
            end
            if (commit)
            begin
                old_h <= new_h; // whole vector in one edge
            end
        end
    end

    assign emb_rd_data = emb[emb_rd_idx];
    assign hid_rd_data = old_h[hid_rd_idx];

endmodule

/* rnn_core/step_sequencer.sv */
`timescale 1ns/10ps

module step_sequencer #(
    parameter int HID_SIZE = 8,
    parameter int EMB_SIZE = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               execute,
    input  logic        [6:0]                  token,
    weight_rd_if.initiator                     rd,
    mac_if.initiator                           mac,
    output logic                               emb_wr_en,
    output logic        [$clog2(EMB_SIZE)-1:0] emb_wr_idx,
    output logic        [$clog2(EMB_SIZE)-1:0] emb_rd_idx,
    output logic        [$clog2(HID_SIZE)-1:0] hid_rd_idx,
    input  logic signed [rnn_pkg::DATA_W-1:0]  emb_rd_data,
    input  logic signed [rnn_pkg::DATA_W-1:0]  hid_rd_data,
    output logic                               hid_wr_en,
    output logic        [$clog2(HID_SIZE)-1:0] hid_wr_idx,
    output logic                               commit,
    output logic                               busy,
    output logic                               step_done
);

    localparam int HID_W = $clog2(HID_SIZE);
    localparam int EMB_W = $clog2(EMB_SIZE);
    localparam int CNT_W = $clog2((HID_SIZE > EMB_SIZE) ? HID_SIZE : EMB_SIZE);
    localparam int AW    = rnn_pkg::ADDR_W;

    localparam logic [CNT_W-1:0] HID_LAST = CNT_W'(HID_SIZE - 1);
    localparam logic [CNT_W-1:0] EMB_LAST = CNT_W'(EMB_SIZE - 1);
    localparam logic [HID_W-1:0] NRN_LAST = HID_W'(HID_SIZE - 1);

    rnn_pkg::seq_state_t state;
    rnn_pkg::seq_state_t tag_kind; // kind of the read now returning

    logic        [CNT_W-1:0]          cnt;     // term within the current group
    logic        [HID_W-1:0]          neuron;
    logic        [6:0]                token_q;
    logic        [CNT_W-1:0]          tag_idx;
    logic signed [rnn_pkg::DATA_W-1:0] op_q;   // operand waiting for its weight
    int                               addr_int;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= rnn_pkg::S_IDLE;
            tag_kind <= rnn_pkg::S_IDLE;
            cnt      <= '0;
            neuron   <= '0;
        end
        else
        begin
            tag_kind <= state;
            case (state)
                rnn_pkg::S_IDLE, rnn_pkg::S_COMMIT:
                begin
                    if (execute)
                    begin
                        state   <= rnn_pkg::S_EMB;
                        cnt     <= '0;
                        neuron  <= '0;
                        token_q <= token;
                    end
                    else
                    begin
                        state <= rnn_pkg::S_IDLE;
                    end
                end
                rnn_pkg::S_EMB:
                begin
                    cnt <= (cnt == EMB_LAST) ? '0 : cnt + 1'b1;
                    if (cnt == EMB_LAST)
                        state <= rnn_pkg::S_HH_W;
                end
                rnn_pkg::S_HH_W:
                begin
                    cnt <= (cnt == HID_LAST) ? '0 : cnt + 1'b1;
                    if (cnt == HID_LAST)
                        state <= rnn_pkg::S_HH_B;
                end
                rnn_pkg::S_HH_B:
                    state <= rnn_pkg::S_IH_W;
                rnn_pkg::S_IH_W:
                begin
                    cnt <= (cnt == EMB_LAST) ? '0 : cnt + 1'b1;
                    if (cnt == EMB_LAST)
                        state <= rnn_pkg::S_IH_B;
                end
                rnn_pkg::S_IH_B:
                    state <= rnn_pkg::S_WAIT;
                default: // S_WAIT
                begin
                    if (mac.result_valid)
                    begin
                        if (neuron == NRN_LAST)
                        begin
                            state <= rnn_pkg::S_COMMIT;
                        end
                        else
                        begin
                            neuron <= neuron + 1'b1;
                            state  <= rnn_pkg::S_HH_W;
                        end
                    end
                end
            endcase
        end
    end

    // operand is captured with the read, weight arrives a cycle later
    always_ff @(posedge clk)
    begin
        tag_idx <= cnt;
        case (state)
            rnn_pkg::S_HH_W: op_q <= hid_rd_data;
            rnn_pkg::S_IH_W: op_q <= emb_rd_data;
            default:         op_q <= rnn_pkg::FIX_ONE;
        endcase
    end

    always_comb
    begin
        case (state)
            rnn_pkg::S_EMB:
                addr_int = rnn_pkg::EMB_BASE + int'(token_q) * EMB_SIZE + int'(cnt);
            rnn_pkg::S_HH_W:
                addr_int = rnn_pkg::W_HH_BASE + int'(neuron) * HID_SIZE + int'(cnt);
            rnn_pkg::S_HH_B:
                addr_int = rnn_pkg::B_HH_BASE + int'(neuron);
            rnn_pkg::S_IH_W:
                addr_int = rnn_pkg::W_IH_BASE + int'(neuron) * EMB_SIZE + int'(cnt);
            rnn_pkg::S_IH_B:
                addr_int = rnn_pkg::B_IH_BASE + int'(neuron);
            default:
                addr_int = 0;
        endcase
    end

    assign rd.en   = state inside {rnn_pkg::S_EMB, rnn_pkg::S_HH_W, rnn_pkg::S_HH_B,
                                   rnn_pkg::S_IH_W, rnn_pkg::S_IH_B};
    assign rd.addr = AW'(addr_int);

    assign emb_rd_idx = EMB_W'(cnt);
    assign hid_rd_idx = HID_W'(cnt);

    // returned embedding words go to the bank, all others to the accumulator
    assign emb_wr_en  = rd.data_valid && (tag_kind == rnn_pkg::S_EMB);
    assign emb_wr_idx = EMB_W'(tag_idx);

    assign mac.term_valid = rd.data_valid && (tag_kind != rnn_pkg::S_EMB);
    assign mac.weight     = rd.data;
    assign mac.operand    = op_q;
    assign mac.term_first = (tag_kind == rnn_pkg::S_HH_W) && (tag_idx == '0);
    assign mac.term_last  = tag_kind == rnn_pkg::S_IH_B;

    assign hid_wr_en  = mac.result_valid;
    assign hid_wr_idx = neuron;

    assign commit    = state == rnn_pkg::S_COMMIT;
    assign step_done = state == rnn_pkg::S_COMMIT;
    assign busy      = !(state inside {rnn_pkg::S_IDLE, rnn_pkg::S_COMMIT});

endmodule

/* run.sh */
#!/bin/sh
# builds the rnn cell testbench with verilator, runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rnn_cell_tb -f list.f -o rnn_sim \
    && ./obj_dir/rnn_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation FAILED"; exit 1; }

/* tb/rnn_cell_chk.sv */
`timescale 1ns/10ps

module rnn_cell_chk (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 busy,
    input logic                                 step_done,
    input logic                                 hidden_valid,
    input logic [$clog2(rnn_pkg::HID_SIZE)-1:0] hidden_index
);

    localparam int IDX_W = $clog2(rnn_pkg::HID_SIZE);

    int               fail_count;
    logic [IDX_W-1:0] last_index; // index of the previous hidden output

    initial fail_count = 0;

    always_ff @(posedge clk)
    begin
        if (reset)
            last_index <= '0;
        else if (hidden_valid)
            last_index <= hidden_index;
    end

    idle_after_reset: assert property (@(posedge clk) $past(reset) |-> !busy && !step_done)
        else
        begin
            $error("busy or step_done high in the cycle after reset");
            fail_count++;
        end

    done_inside_step: assert property (@(posedge clk) disable iff (reset)
        step_done |-> $past(busy))
        else
        begin
            $error("step_done without a running step");
            fail_count++;
        end

    valid_inside_step: assert property (@(posedge clk) disable iff (reset)
        hidden_valid |-> busy)
        else
        begin
            $error("hidden_valid while not busy");
            fail_count++;
        end

    // each step restarts at neuron zero
    index_in_order: assert property (@(posedge clk) disable iff (reset)
        hidden_valid && (hidden_index != '0) |-> hidden_index == IDX_W'(last_index + 1'b1))
        else
        begin
            $error("hidden_index out of order");
            fail_count++;
        end

endmodule

bind rnn_cell_top rnn_cell_chk i_chk (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .step_done    (step_done),
    .hidden_valid (hidden_valid),
    .hidden_index (hidden_index)
);

/* tb/rnn_cell_tb.sv */
`timescale 1ns/10ps

module rnn_cell_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int STEP_CYCLES  = 200; // generous bound on one step
    localparam int HID          = rnn_pkg::HID_SIZE;
    localparam int EMB          = rnn_pkg::EMB_SIZE;
    localparam int ONE          = 1 << rnn_pkg::FRAC_BITS;
    localparam int MAX_VAL      = (1 << (rnn_pkg::DATA_W - 1)) - 1;

    logic                                 clk;
    logic                                 reset;
    logic                                 wt_wr_en;
    logic        [rnn_pkg::ADDR_W-1:0]    wt_wr_addr;
    logic        [rnn_pkg::DATA_W-1:0]    wt_wr_data;
    logic        [6:0]                    token;
    logic                                 execute;
    logic                                 busy;
    logic                                 hidden_valid;
    logic        [$clog2(HID)-1:0]        hidden_index;
    logic signed [rnn_pkg::DATA_W-1:0]    hidden_value;
    logic                                 step_done;

    string test_name [$];
    int    test_reset [$];
    int    test_token [$];
    int    test_scale [$];
    int    test_steps [$];

    logic signed [rnn_pkg::DATA_W-1:0] weights [rnn_pkg::MEM_DEPTH]; // copy of the memory
    logic signed [rnn_pkg::DATA_W-1:0] model_h [HID];
    logic signed [rnn_pkg::DATA_W-1:0] expect_h [HID];

    string cur_test;
    int    seed;
    int    limit_cycles;
    int    total_steps;
    int    relu_hits;
    int    sat_hits;

    rnn_cell_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_value(input string what, input int exp, input int act);
        $display("** Error %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_test(input string msg);
        $display("%s: %s", cur_test, msg);
        $display("Testbench failed");
        $fatal(1, "check failed");
    endtask

    task automatic read_stim();
        int    fd;
        int    n;
        string line;
        string name;
        int    rst;
        int    tok;
        int    scl;
        int    stp;
        fd = $fopen("tb/rnn_stim.txt", "r");
        if (fd == 0)
            abort_test("cannot open tb/rnn_stim.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%s %d %d %d %d", name, rst, tok, scl, stp);
                if (n == 5)
                begin
                    if (tok < 0 || tok >= rnn_pkg::VOCAB_SIZE || scl < 2 || scl > 16)
                        abort_test({"bad token or scale on stimulus line ", name});
                    test_name.push_back(name);
                    test_reset.push_back(rst);
                    test_token.push_back(tok);
                    test_scale.push_back(scl);
                    test_steps.push_back(stp);
                end
            end
        end
        $fclose(fd);
        if (test_name.size() == 0)
            abort_test("the stimulus file holds no tests");
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        assert (!busy && !hidden_valid && !step_done)
            else abort_test("outputs not idle after reset");
        for (int k = 0; k < HID; k++)
            model_h[k] = '0;
    endtask

    // keeps the low scale bits of each random word sign extended
    task automatic load_weights(input int scale);
        int raw;
        int shift;
        shift = 32 - scale;
        for (int a = 0; a < rnn_pkg::MEM_DEPTH; a++)
        begin
            raw = $random(seed);
            raw = (raw <<< shift) >>> shift;
            weights[a] = 16'(raw);
            @(negedge clk);
            wt_wr_en   = 1'b1;
            wt_wr_addr = 9'(a);
            wt_wr_data = 16'(raw);
        end
        @(negedge clk);
        wt_wr_en = 1'b0;
    endtask

    // one recurrent step by the fixed-point rule with 32 bit wrapping sums
    task automatic model_step(input int tok);
        int acc;
        int scaled;
        for (int j = 0; j < HID; j++)
        begin
            acc = 0;
            for (int k = 0; k < HID; k++)
                acc += int'(weights[rnn_pkg::W_HH_BASE + j * HID + k]) * int'(model_h[k]);
            acc += int'(weights[rnn_pkg::B_HH_BASE + j]) * ONE;
            for (int k = 0; k < EMB; k++)
                acc += int'(weights[rnn_pkg::W_IH_BASE + j * EMB + k])
                     * int'(weights[rnn_pkg::EMB_BASE + tok * EMB + k]);
            acc += int'(weights[rnn_pkg::B_IH_BASE + j]) * ONE;
            scaled = acc >>> rnn_pkg::FRAC_BITS;
            if (scaled < 0)
            begin
                expect_h[j] = '0;
                relu_hits++;
            end
            else if (scaled > MAX_VAL)
            begin
                expect_h[j] = 16'(MAX_VAL);
                sat_hits++;
            end
            else
                expect_h[j] = 16'(scaled);
        end
    endtask

    task automatic run_step(input int t, input bit poke);
        int n_valid;
        int since_valid;
        bit poked;
        bit finished;
        n_valid     = 0;
        since_valid = 0;
        poked       = 1'b0;
        finished    = 1'b0;
        model_step(test_token[t]);
        @(negedge clk);
        token   = 7'(test_token[t]);
        execute = 1'b1;
        @(negedge clk);
        execute = 1'b0;
        assert (busy) else abort_test("busy did not rise after execute");
        while (!finished)
        begin
            if (hidden_valid)
            begin
                assert (n_valid < HID) else abort_test("more than eight hidden outputs");
                assert (int'(hidden_index) == n_valid)
                    else fail_value("hidden_index", n_valid, int'(hidden_index));
                assert (hidden_value == expect_h[n_valid])
                    else fail_value($sformatf("hidden_value[%0d]", n_valid),
                                    int'(expect_h[n_valid]), int'(hidden_value));
                n_valid++;
                since_valid = 0;
                if (poke && !poked)
                begin
                    execute = 1'b1; // must be ignored mid step
                    poked   = 1'b1;
                end
            end
            else
            begin
                execute = 1'b0;
                since_valid++;
            end
            if (step_done)
            begin
                assert (n_valid == HID) else fail_value("hidden outputs per step", HID, n_valid);
                assert (since_valid == 1)
                    else abort_test("step_done not one cycle after last output");
                assert (!busy) else abort_test("busy still high with step_done");
                finished = 1'b1;
            end
            else
                @(negedge clk);
        end
        repeat (3)
        begin
            @(negedge clk);
            assert (!busy && !hidden_valid && !step_done)
                else abort_test("DUT kept running after step_done");
        end
        for (int k = 0; k < HID; k++)
            model_h[k] = expect_h[k];
    endtask

    // watchdog sized from the test table
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped finishing its steps", limit_cycles);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        reset        = 1'b1;
        wt_wr_en     = 1'b0;
        wt_wr_addr   = '0;
        wt_wr_data   = '0;
        token        = '0;
        execute      = 1'b0;
        seed         = 21;
        relu_hits    = 0;
        sat_hits     = 0;
        total_steps  = 0;
        limit_cycles = 0;
        cur_test     = "stimulus file";
        read_stim();
        foreach (test_steps[i])
            total_steps += test_steps[i];
        limit_cycles = 2 * (test_name.size() * rnn_pkg::MEM_DEPTH + total_steps * STEP_CYCLES);
        apply_reset();
        foreach (test_name[t])
        begin
            cur_test = test_name[t];
            if (test_reset[t] != 0)
                apply_reset();
            load_weights(test_scale[t]);
            for (int s = 0; s < test_steps[t]; s++)
                run_step(t, (s % 2) == 1);
        end
        cur_test = "summary";
        assert (relu_hits > 0) else abort_test("no neuron was clamped to zero in any test");
        assert (sat_hits > 0) else abort_test("no neuron reached the saturated maximum");
        if (i_dut.i_chk.fail_count == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("protocol assertions in the bound checker failed");
            $display("Testbench failed");
            $fatal(1, "checker failures");
        end
    end

endmodule

/* tb/rnn_stim.txt */
# columns: name reset token scale steps
# scale is the number of weight bits kept and sign extended, 16 is the full range
single_step    1   5  10  1
sequence       0  17  10  6
relu_small     1  42   7  3
saturate_big   1  63  16  2
busy_execute   0   0  12  4
last_token     1  75  11  3
reload_keep    0  33   9  5
